// File: trainer_pkg.sv
// Activation trainer shared definitions
// Fixed point format, stream element types and the truncating multiply
// used by the derivative pipeline and the gradient sums

package trainer_pkg;

  ////////////////////////////////////////
  // Fixed point format
  ////////////////////////////////////////

  parameter int DATA_W = 16;  // Word width
  parameter int FRAC_W = 8;   // Fraction bits
  parameter int IDX_FIELD_W = 8;  // Index field, room for 256 elements

  typedef logic signed [DATA_W-1:0] fix_t;
  typedef logic [IDX_FIELD_W-1:0] idx_t;

  parameter fix_t ONE_FIX = fix_t'(1 << FRAC_W);  // 1.0

  ////////////////////////////////////////
  // Stream element types
  ////////////////////////////////////////

  // One input element, 80 bits
  typedef struct packed {
    fix_t a;   // Activation
    fix_t i;   // Input gate
    fix_t ds;  // State gradient
    fix_t x;   // Input vector element
    fix_t h;   // Hidden output element
  } sample_t;

  // Operands that meet da in the accumulator
  typedef struct packed {
    fix_t x;
    fix_t h_prev;     // h of the previous step, same index
    logic has_prev;   // Previous step exists
    idx_t idx;        // Element index
  } aligned_t;

  // One output element, 48 bits
  typedef struct packed {
    fix_t dw;
    fix_t du;
    fix_t db;
  } grad_t;

  // Signed product, truncated by an arithmetic shift
  function automatic fix_t fix_mul(fix_t op_a, fix_t op_b);
    logic signed [2*DATA_W-1:0] prod;
    logic signed [2*DATA_W-1:0] shifted;
    prod = op_a * op_b;
    shifted = prod >>> FRAC_W;
    return shifted[DATA_W-1:0];  // Upper bits dropped, wraps
  endfunction

endpackage

// File: activation_derivative.sv
// Activation derivative pipeline
// da = ds * i * (1 - a^2) in three register stages
// A valid bit rides along, so a new element may enter every cycle

`timescale 1ns/1ps

module activation_derivative (
  input  logic               CLK,
  input  logic               RST,
  input  logic               in_valid,
  input  trainer_pkg::fix_t  a,
  input  trainer_pkg::fix_t  i,
  input  trainer_pkg::fix_t  ds,
  output logic               da_valid,
  output trainer_pkg::fix_t  da
);

  ////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////

  logic              s1_valid;
  logic              s2_valid;
  trainer_pkg::fix_t s1_a_sq;   // a^2
  trainer_pkg::fix_t s1_i;
  trainer_pkg::fix_t s1_ds;
  trainer_pkg::fix_t s2_gate;   // (1 - a^2) * i
  trainer_pkg::fix_t s2_ds;
  trainer_pkg::fix_t one_minus; // 1 - a^2, wraps

  assign one_minus = trainer_pkg::fix_t'(trainer_pkg::ONE_FIX - s1_a_sq);

  // Valid chain
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      da_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
      s2_valid <= s1_valid;
      da_valid <= s2_valid;  // Three cycles after the strobe
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Stage 1, square and hold the gate operands
    s1_a_sq <= trainer_pkg::fix_mul(a, a);
    s1_i    <= i;
    s1_ds   <= ds;

    // Stage 2
    s2_gate <= trainer_pkg::fix_mul(one_minus, s1_i);
    s2_ds   <= s1_ds;

    // Stage 3, scale by the state gradient
    da <= trainer_pkg::fix_mul(s2_gate, s2_ds);
  end

endmodule

// File: operand_align.sv
// Operand alignment for the gradient sums
// Tracks the element index, keeps h of the previous time step and
// delays x, h_prev and flush so they meet da in the same cycle

`timescale 1ns/1ps

module operand_align #(
  parameter int NUM_ELEM = 8,
  parameter int IDX_W    = 3
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic                  in_valid,
  input  logic                  flush,
  input  trainer_pkg::sample_t  sample,
  output trainer_pkg::aligned_t aligned,
  output logic                  flush_aligned
);

  logic [IDX_W-1:0]      cnt;        // Element index of the next strobe
  logic                  step_seen;  // One full step done
  logic                  cnt_last;
  trainer_pkg::fix_t     h_mem [NUM_ELEM];  // h of the last step
  trainer_pkg::aligned_t stage [3];  // Matches the derivative depth
  logic [2:0]            flush_pipe;

  assign cnt_last = (cnt == IDX_W'(NUM_ELEM - 1));

  ////////////////////////////////////////
  // Index and step tracking
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      cnt       <= '0;
      step_seen <= 1'b0;
    end else if (start) begin
      cnt       <= '0;  // New run, no history
      step_seen <= 1'b0;
    end else if (in_valid) begin
      if (cnt_last) begin
        cnt       <= '0;
        step_seen <= 1'b1;  // Next step pairs with this one
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Flush travels with the data stages
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      flush_pipe <= '0;
    end else begin
      flush_pipe <= {flush_pipe[1:0], flush};
    end
  end

  ////////////////////////////////////////
  // History memory and operand delay
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    stage[0].x        <= sample.x;
    stage[0].h_prev   <= h_mem[cnt];  // Old entry, read before write
    stage[0].has_prev <= step_seen;
    stage[0].idx      <= trainer_pkg::idx_t'(cnt);
    stage[1] <= stage[0];
    stage[2] <= stage[1];
    if (in_valid) h_mem[cnt] <= sample.h;
  end

  assign aligned       = stage[2];
  assign flush_aligned = flush_pipe[2];

endmodule

// File: gradient_accumulator.sv
// Gradient accumulator
// Per element sums of dW, dU and db over all time steps
// A flush streams every element out, then ready pulses once

`timescale 1ns/1ps

module gradient_accumulator #(
  parameter int NUM_ELEM = 8,
  parameter int IDX_W    = 3
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic                  da_valid,
  input  logic                  flush_aligned,
  input  trainer_pkg::fix_t     da,
  input  trainer_pkg::aligned_t aligned,
  output logic                  result_valid,
  output trainer_pkg::grad_t    result,
  output logic [IDX_W-1:0]      result_idx,
  output logic                  ready
);

  ////////////////////////////////////////
  // Sum storage
  ////////////////////////////////////////

  trainer_pkg::fix_t sum_w [NUM_ELEM];
  trainer_pkg::fix_t sum_u [NUM_ELEM];
  trainer_pkg::fix_t sum_b [NUM_ELEM];

  logic [IDX_W-1:0]  wr_idx;    // Target element
  trainer_pkg::fix_t prod_x;    // da * x
  trainer_pkg::fix_t prod_h;    // da * h_prev
  logic [IDX_W-1:0]  rd_sel;    // Element loaded into result
  logic              rd_load;
  logic              last_idx;

  assign wr_idx = aligned.idx[IDX_W-1:0];
  assign prod_x = trainer_pkg::fix_mul(da, aligned.x);
  assign prod_h = trainer_pkg::fix_mul(da, aligned.h_prev);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int e = 0; e < NUM_ELEM; e++) begin
        sum_w[e] <= '0;
        sum_u[e] <= '0;
        sum_b[e] <= '0;
      end
    end else if (start) begin
      for (int e = 0; e < NUM_ELEM; e++) begin
        sum_w[e] <= '0;  // Drop the previous run
        sum_u[e] <= '0;
        sum_b[e] <= '0;
      end
    end else if (da_valid) begin
      sum_w[wr_idx] <= sum_w[wr_idx] + prod_x;  // Sums wrap
      if (aligned.has_prev) begin
        sum_u[wr_idx] <= sum_u[wr_idx] + prod_h;  // da(t+1) with h(t)
      end
      sum_b[wr_idx] <= sum_b[wr_idx] + da;
    end
  end

  ////////////////////////////////////////
  // Readout
  ////////////////////////////////////////

  assign last_idx = (result_idx == IDX_W'(NUM_ELEM - 1));
  assign rd_load  = flush_aligned || (result_valid && !last_idx);
  assign rd_sel   = flush_aligned ? '0 : result_idx + 1'b1;

  // Readout control
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result_valid <= 1'b0;
      result_idx   <= '0;
      ready        <= 1'b0;
    end else begin
      ready <= 1'b0;  // Single cycle pulse
      if (flush_aligned) begin
        result_valid <= 1'b1;
        result_idx   <= '0;
      end else if (result_valid) begin
        if (last_idx) begin
          result_valid <= 1'b0;
          ready        <= 1'b1;  // Cycle after the last element
        end else begin
          result_idx <= result_idx + 1'b1;
        end
      end
    end
  end

  // Result payload, one element per cycle
  always_ff @(posedge CLK) begin
    if (rd_load) begin
      result.dw <= sum_w[rd_sel];
      result.du <= sum_u[rd_sel];
      result.db <= sum_b[rd_sel];
    end
  end

endmodule

// File: activation_trainer.sv
// Activation trainer top level
// Streams the activation stage gradients dW, dU and db
// The derivative pipeline and the operand alignment run side by side
// and meet in the accumulator

`timescale 1ns/1ps

module activation_trainer #(
  parameter int NUM_ELEM = 8
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  logic                 sample_valid,
  input  logic                 flush,
  input  trainer_pkg::sample_t sample,
  output logic                 result_valid,
  output trainer_pkg::grad_t   result,
  output logic [((NUM_ELEM > 1) ? $clog2(NUM_ELEM) : 1)-1:0] result_idx,
  output logic                 ready
);

  localparam int IDX_W = (NUM_ELEM > 1) ? $clog2(NUM_ELEM) : 1;

  logic                  da_valid;
  trainer_pkg::fix_t     da;
  trainer_pkg::aligned_t aligned;
  logic                  flush_aligned;

  ////////////////////////////////////////
  // Two parallel three cycle paths
  ////////////////////////////////////////

  activation_derivative u_deriv (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (sample_valid),
    .a        (sample.a),
    .i        (sample.i),
    .ds       (sample.ds),
    .da_valid (da_valid),
    .da       (da)
  );

  operand_align #(
    .NUM_ELEM (NUM_ELEM),
    .IDX_W    (IDX_W)
  ) u_align (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .in_valid      (sample_valid),
    .flush         (flush),
    .sample        (sample),
    .aligned       (aligned),
    .flush_aligned (flush_aligned)
  );

  // Sums and readout
  gradient_accumulator #(
    .NUM_ELEM (NUM_ELEM),
    .IDX_W    (IDX_W)
  ) u_accum (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .da_valid      (da_valid),
    .flush_aligned (flush_aligned),
    .da            (da),
    .aligned       (aligned),
    .result_valid  (result_valid),
    .result        (result),
    .result_idx    (result_idx),
    .ready         (ready)
  );

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset source
// Free running clock, reset held high for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 16
) (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2.0) CLK = ~CLK;
  end

  initial begin
    RST = 1'b1;  // High from time zero
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

// File: tb_activation_trainer.sv
// Testbench for the activation trainer
// Directed runs with fixed and LFSR stimulus, each checked against a
// fixed point model of the da, dW, dU and db rules

`timescale 1ns/1ps

module tb_activation_trainer;

  localparam int NUM_ELEM      = 8;
  localparam int IDX_W         = (NUM_ELEM > 1) ? $clog2(NUM_ELEM) : 1;
  localparam int LATENCY       = 4;    // flush to first result
  localparam int TOTAL_SAMPLES = 128;  // All runs together
  localparam int NUM_RUNS      = 8;
  // Gaps stretch a sample to at most 4 cycles
  localparam int MAX_CYCLES = 2 * (16 + 4 * TOTAL_SAMPLES + NUM_RUNS * (NUM_ELEM + 10));

  logic                 CLK;
  logic                 RST;
  logic                 start;
  logic                 sample_valid;
  logic                 flush;
  trainer_pkg::sample_t sample;
  logic                 result_valid;
  trainer_pkg::grad_t   result;
  logic [IDX_W-1:0]     result_idx;
  logic                 ready;

  trainer_pkg::sample_t stim [$];        // Current run, step after step
  trainer_pkg::grad_t   exp_g [NUM_ELEM];  // Model results
  trainer_pkg::grad_t   got_g [NUM_ELEM];  // Last readout
  logic [31:0]          lfsr = 32'd75894;
  int                   cycle_cnt = 0;
  int                   error_cnt = 0;
  int                   tests_run = 0;
  int                   tests_failed = 0;

  tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(16)) clk_gen (.CLK(CLK), .RST(RST));

  activation_trainer #(.NUM_ELEM(NUM_ELEM)) dut0 (
    .CLK(CLK), .RST(RST), .start(start), .sample_valid(sample_valid), .flush(flush),
    .sample(sample), .result_valid(result_valid), .result(result),
    .result_idx(result_idx), .ready(ready)
  );

  // Run length guard
  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus and model
  ////////////////////////////////////////

  // Fibonacci x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic        fb;
    logic [31:0] val;
    val = '0;
    for (int b = 0; b < n; b++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic trainer_pkg::fix_t rand_fix(input int n);
    logic [31:0] raw;
    raw = take_bits(n);
    return trainer_pkg::fix_t'($signed(raw << (32 - n)) >>> (32 - n));  // Sign extend
  endfunction

  function automatic trainer_pkg::sample_t make_sample(
      input trainer_pkg::fix_t a, i, ds, x, h);
    trainer_pkg::sample_t s;
    s.a  = a;
    s.i  = i;
    s.ds = ds;
    s.x  = x;
    s.h  = h;
    return s;
  endfunction

  function automatic trainer_pkg::grad_t make_grad(input trainer_pkg::fix_t dw, du, db);
    trainer_pkg::grad_t g;
    g.dw = dw;
    g.du = du;
    g.db = db;
    return g;
  endfunction

  // Full product truncated to the low word
  function automatic trainer_pkg::fix_t model_mul(input trainer_pkg::fix_t p,
                                                  input trainer_pkg::fix_t q);
    longint full;
    full = longint'(p) * longint'(q);
    return trainer_pkg::fix_t'(full >>> trainer_pkg::FRAC_W);
  endfunction

  task automatic add_random_steps(input int steps);
    repeat (steps * NUM_ELEM) begin
      stim.push_back(make_sample(rand_fix(10), rand_fix(9), rand_fix(12),  // a about +-2.0
                                 rand_fix(12), rand_fix(12)));
    end
  endtask

  // Expected sums for the whole stim queue
  task automatic build_model();
    trainer_pkg::fix_t h_last [NUM_ELEM];
    trainer_pkg::fix_t gate;
    trainer_pkg::fix_t da;
    int                l;
    for (int e = 0; e < NUM_ELEM; e++) exp_g[e] = '0;
    foreach (stim[k]) begin
      l    = k % NUM_ELEM;
      gate = trainer_pkg::ONE_FIX - model_mul(stim[k].a, stim[k].a);  // 1 - a^2 wraps
      da   = model_mul(model_mul(gate, stim[k].i), stim[k].ds);
      exp_g[l].dw += model_mul(da, stim[k].x);
      if (k >= NUM_ELEM) exp_g[l].du += model_mul(da, h_last[l]);  // da(t+1) with h(t)
      exp_g[l].db += da;
      h_last[l] = stim[k].h;
    end
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic check_grad(input string what, input trainer_pkg::grad_t got,
                            input trainer_pkg::grad_t want);
    if (got !== want) begin
      error_cnt++;
      $display("mismatch at %0d ns: %s dw/du/db got %0d/%0d/%0d expected %0d/%0d/%0d",
               $time, what, got.dw, got.du, got.db, want.dw, want.du, want.db);
    end
  endtask

  task automatic check_idx(input string what, input logic [IDX_W-1:0] got,
                           input logic [IDX_W-1:0] want);
    if (got !== want) begin
      error_cnt++;
      $display("mismatch at %0d ns: %s result_idx %0d expected %0d", $time, what, got, want);
    end
  endtask

  task automatic check_latency(input string what, input int got, input int want);
    if (got != want) begin
      error_cnt++;
      $display("%s: result_valid came %0d cycles after flush instead of %0d", what, got, want);
    end
  endtask

  // start, all samples, flush, then readout of every element
  task automatic run_stream(input string what, input bit gaps);
    int t0;
    int lat;
    build_model();
    @(posedge CLK);
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
    foreach (stim[k]) begin
      if (gaps) begin
        repeat (take_bits(2)) begin  // 0 to 3 idle cycles
          @(posedge CLK);
          sample_valid <= 1'b0;
        end
      end
      @(posedge CLK);
      sample_valid <= 1'b1;
      sample       <= stim[k];
    end
    @(posedge CLK);
    sample_valid <= 1'b0;
    flush        <= 1'b1;
    @(negedge CLK);
    t0 = cycle_cnt;  // Cycle in which flush is seen
    @(posedge CLK);
    flush <= 1'b0;
    do begin
      @(negedge CLK);
      lat = cycle_cnt - t0;
    end while (!result_valid && lat < 4 * LATENCY);
    if (!result_valid) begin
      error_cnt++;
      $display("%s: result_valid never came after flush", what);
      return;
    end
    check_latency(what, lat, LATENCY);
    for (int e = 0; e < NUM_ELEM; e++) begin
      if (!result_valid) begin
        error_cnt++;
        $display("%s: result_valid dropped before element %0d", what, e);
      end
      if (ready) begin
        error_cnt++;
        $display("%s: ready was high during readout at element %0d", what, e);
      end
      check_idx(what, result_idx, IDX_W'(e));
      check_grad(what, result, exp_g[e]);
      got_g[e] = result;
      @(negedge CLK);
    end
    if (result_valid || !ready) begin
      error_cnt++;
      $display("%s: ready did not pulse right after the last result", what);
    end
    @(negedge CLK);
    if (ready) begin
      error_cnt++;
      $display("%s: ready stayed high for more than one cycle", what);
    end
  endtask

  task automatic report(input int num, input string name, input int errs_before);
    tests_run++;
    if (error_cnt == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, error_cnt - errs_before);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_one_step();
    int base;
    base = error_cnt;
    stim.delete();
    for (int e = 0; e < NUM_ELEM; e++) begin  // a 0.5, i 1.0, ds 2.0 gives da 1.5
      stim.push_back(make_sample(128, 256, 512, trainer_pkg::fix_t'(64 * (e + 1)), 300));
    end
    run_stream("one step", 1'b0);
    for (int e = 0; e < NUM_ELEM; e++) begin
      check_grad("one step by hand", got_g[e],
                 make_grad(trainer_pkg::fix_t'(96 * (e + 1)), 0, 384));  // No history so dU 0
    end
    report(1, "one step fixed values", base);
  endtask

  task automatic test_three_steps();
    int base;
    base = error_cnt;
    stim.delete();
    add_random_steps(3);
    run_stream("three steps", 1'b0);
    report(2, "three steps lfsr", base);
  endtask

  task automatic test_gaps();
    int                 base;
    trainer_pkg::grad_t saved [NUM_ELEM];
    base = error_cnt;
    stim.delete();
    add_random_steps(3);
    run_stream("back to back", 1'b0);
    saved = got_g;
    run_stream("with gaps", 1'b1);
    for (int e = 0; e < NUM_ELEM; e++) check_grad("gaps vs back to back", got_g[e], saved[e]);
    report(3, "random gaps", base);
  endtask

  task automatic test_restart();
    int base;
    base = error_cnt;
    stim.delete();
    add_random_steps(2);
    run_stream("first run", 1'b0);
    stim.delete();
    add_random_steps(1);
    run_stream("after start", 1'b0);  // Model starts from zero
    for (int e = 0; e < NUM_ELEM; e++) begin
      check_grad("history cleared", got_g[e], make_grad(exp_g[e].dw, 0, exp_g[e].db));
    end
    report(4, "second run after start", base);
  endtask

  task automatic test_readout_timing();
    int base;
    base = error_cnt;
    stim.delete();
    add_random_steps(1);
    run_stream("readout timing", 1'b0);  // Latency and index run and ready checked inside
    report(5, "readout timing", base);
  endtask

  task automatic test_saturated_and_wrap();
    int base;
    base = error_cnt;
    stim.delete();
    repeat (2) begin
      for (int e = 0; e < NUM_ELEM; e++) begin
        if (e < NUM_ELEM / 2) begin  // a = +-1.0
          stim.push_back(make_sample((e % 2) ? -trainer_pkg::ONE_FIX : trainer_pkg::ONE_FIX,
                                     rand_fix(9), rand_fix(12), rand_fix(12), rand_fix(12)));
        end else begin  // da = ds with products past full scale
          stim.push_back(make_sample(0, trainer_pkg::ONE_FIX, 16'sh6000, 16'sh0400, 16'sh0200));
        end
      end
    end
    run_stream("saturated and wrap", 1'b0);
    for (int e = 0; e < NUM_ELEM; e++) begin
      if (e < NUM_ELEM / 2) check_grad("da zero at a=+-1", got_g[e], make_grad(0, 0, 0));
      else check_grad("db wraps", got_g[e], make_grad(exp_g[e].dw, exp_g[e].du, 16'shC000));
    end
    report(6, "a at +-1.0 and wrapping sums", base);
  endtask

  initial begin
    start        = 1'b0;
    sample_valid = 1'b0;
    flush        = 1'b0;
    sample       = '0;
    @(negedge RST);
    test_one_step();
    test_three_steps();
    test_gaps();
    test_restart();
    test_readout_timing();
    test_saturated_and_wrap();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_cnt);
    if (error_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: sim.f
trainer_pkg.sv
activation_derivative.sv
operand_align.sv
gradient_accumulator.sv
activation_trainer.sv
tb_clock_gen.sv
tb_activation_trainer.sv
